// File: hdl/icache_pkg.sv
// Instruction cache shared definitions: geometry, address fields, FSM states, array write ports
package icache_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Geometry
   ////////////////////////////////////////////////////////////////////////////

   localparam int ADDR_W    = 32;
   localparam int LINE_W    = 128;                        // One fetch beat is one line
   localparam int NB_WAYS   = 4;
   localparam int NB_SETS   = 16;
   localparam int OFFSET_W  = 4;                          // 16 bytes per line
   localparam int SET_W     = 4;                          // Address bits 7:4
   localparam int TAG_W     = ADDR_W - SET_W - OFFSET_W;  // Address bits 31:8

   // Replacement LFSR, x^8 + x^6 + x^5 + x^4 + 1 in Galois form
   localparam logic [7:0] LFSR_SEED = 8'hA5;
   localparam logic [7:0] LFSR_TAPS = 8'hB8;

   ////////////////////////////////////////////////////////////////////////////
   // Types
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [LINE_W-1:0]           line_t;
   typedef logic [SET_W-1:0]            set_idx_t;
   typedef logic [TAG_W-1:0]            tag_t;
   typedef logic [NB_WAYS-1:0]          way_oh_t;
   typedef logic [$clog2(NB_WAYS)-1:0]  way_idx_t;

   // Fetch address split into its cache fields
   typedef struct packed {
      tag_t                tag;
      set_idx_t            set_idx;
      logic [OFFSET_W-1:0] offset;
   } addr_t;

   typedef struct packed {
      logic valid;
      tag_t tag;
   } tag_entry_t;

   typedef enum logic [3:0] {
      DISABLED,
      BYPASS_REFILL,
      FLUSH_ALL,
      FLUSH_SET,
      IDLE,
      TAG_LOOKUP,
      WAIT_REFILL_GNT,
      WAIT_REFILL_DONE
   } ctrl_state_e;

   // Tag write, zero way mask means no write
   typedef struct packed {
      way_oh_t    ways;
      set_idx_t   set_idx;
      tag_entry_t entry;
   } tag_wr_t;

   typedef struct packed {
      way_oh_t  way;
      set_idx_t set_idx;
      line_t    line;
   } data_wr_t;

endpackage

// File: hdl/icache_tag_array.sv
// Tag array: valid bits and tags of all ways, one-cycle read of a set, masked multi-way write
`timescale 1ns/1ps

module icache_tag_array
(
   input  logic                                             clk,
   input  logic                                             rst_n,
   input  logic                                             rd_en_i,
   input  icache_pkg::set_idx_t                             rd_set_i,
   output icache_pkg::tag_entry_t [icache_pkg::NB_WAYS-1:0] rd_entry_o,
   input  icache_pkg::tag_wr_t                              wr_i
);

   icache_pkg::tag_entry_t [icache_pkg::NB_WAYS-1:0] tag_q [icache_pkg::NB_SETS];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int s = 0; s < icache_pkg::NB_SETS; s++)
            tag_q[s] <= '0;                      // All lines invalid
         rd_entry_o <= '0;
      end
      else
      begin
         if (rd_en_i)
            rd_entry_o <= tag_q[rd_set_i];
         for (int w = 0; w < icache_pkg::NB_WAYS; w++)
         begin
            if (wr_i.ways[w])
               tag_q[wr_i.set_idx][w] <= wr_i.entry;
         end
      end
   end

   // Controller never looks up a set while it is being written
   no_rd_wr_same_set: assert property (@(posedge clk) disable iff (!rst_n)
      !(rd_en_i && (|wr_i.ways) && (wr_i.set_idx == rd_set_i)))
      else $error("tag array read and write to the same set");

endmodule

// File: hdl/icache_data_array.sv
// Data array: one 128-bit line per way and set, one-cycle read of a set, single-way write
`timescale 1ns/1ps

module icache_data_array
(
   input  logic                                        clk,
   input  logic                                        rd_en_i,
   input  icache_pkg::set_idx_t                        rd_set_i,
   output icache_pkg::line_t [icache_pkg::NB_WAYS-1:0] rd_line_o,
   input  icache_pkg::data_wr_t                        wr_i
);

   icache_pkg::line_t [icache_pkg::NB_WAYS-1:0] line_q [icache_pkg::NB_SETS];

   always_ff @(posedge clk)
   begin
      if (rd_en_i)
         rd_line_o <= line_q[rd_set_i];          // All ways, hit mux sits in the controller
      for (int w = 0; w < icache_pkg::NB_WAYS; w++)
      begin
         if (wr_i.way[w])
            line_q[wr_i.set_idx][w] <= wr_i.line;
      end
   end

   // Refill lands in exactly the victim way chosen at lookup
   wr_way_onehot: assert property (@(posedge clk) $onehot0(wr_i.way))
      else $error("data array write to more than one way");

endmodule

// File: hdl/icache_tag_check.sv
// Tag check: compares the looked-up tag against all ways, gives hit way and victim way
`timescale 1ns/1ps

module icache_tag_check
(
   input  icache_pkg::tag_entry_t [icache_pkg::NB_WAYS-1:0] entry_i,
   input  icache_pkg::tag_t                                 tag_i,
   input  icache_pkg::way_oh_t                              random_way_i,
   output logic                                             hit_o,
   output icache_pkg::way_idx_t                             hit_way_o,
   output icache_pkg::way_oh_t                              victim_way_o,
   output logic                                             all_valid_o
);

   icache_pkg::way_oh_t valid;
   icache_pkg::way_oh_t match;
   icache_pkg::way_oh_t free_way;

   always_comb
   begin
      free_way  = '0;
      hit_way_o = '0;
      for (int w = 0; w < icache_pkg::NB_WAYS; w++)
      begin
         valid[w] = entry_i[w].valid;
         match[w] = entry_i[w].valid && (entry_i[w].tag == tag_i);
         // Highest invalid way wins
         if (!valid[w])
            free_way = icache_pkg::way_oh_t'(1 << w);
         if (match[w])
            hit_way_o = icache_pkg::way_idx_t'(w);
      end
      // Refill only on a miss, so a set never holds the same tag twice
      assert final ($onehot0(match))
         else $error("tag hit in more than one way");
   end

   assign hit_o        = |match;
   assign all_valid_o  = &valid;
   assign victim_way_o = all_valid_o ? random_way_i : free_way;   // Evict only when set is full

endmodule

// File: hdl/icache_way_lfsr.sv
// Replacement LFSR: 8-bit Galois sequence, low bits decoded to a one-hot random way
`timescale 1ns/1ps

module icache_way_lfsr
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic                step_i,
   output icache_pkg::way_oh_t way_o
);

   logic [7:0] lfsr_q;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         lfsr_q <= icache_pkg::LFSR_SEED;
      else if (step_i)
      begin
         // Shift right, fold taps back in when a one drops out
         lfsr_q <= {1'b0, lfsr_q[7:1]} ^ (lfsr_q[0] ? icache_pkg::LFSR_TAPS : 8'h00);
      end
   end

   assign way_o = icache_pkg::way_oh_t'(1) << icache_pkg::way_idx_t'(lfsr_q);

endmodule

// File: hdl/icache_ctrl_fsm.sv
// Instruction cache controller: bypass, full and set flush, pipelined lookup, miss refill
`timescale 1ns/1ps

module icache_ctrl_fsm
(
   input  logic                                        clk,
   input  logic                                        rst_n,
   input  logic                                        bypass_i,
   input  logic                                        flush_i,
   input  logic                                        flush_set_req_i,
   input  icache_pkg::addr_t                           flush_set_addr_i,
   // Fetch port from the processor
   input  logic                                        fetch_req_i,
   input  icache_pkg::addr_t                           fetch_addr_i,
   output logic                                        fetch_gnt_o,
   output logic                                        fetch_rvalid_o,
   output icache_pkg::line_t                           fetch_rdata_o,
   // Refill port to L2
   output logic                                        refill_req_o,
   output icache_pkg::addr_t                           refill_addr_o,
   input  logic                                        refill_gnt_i,
   input  logic                                        refill_rvalid_i,
   input  icache_pkg::line_t                           refill_rdata_i,
   output logic                                        cache_is_bypassed_o,
   output logic                                        cache_is_flushed_o,
   output logic                                        flush_set_ack_o,
   // Arrays, tag check and LFSR
   output logic                                        rd_en_o,
   output icache_pkg::set_idx_t                        rd_set_o,
   output icache_pkg::tag_t                            lookup_tag_o,
   input  icache_pkg::line_t [icache_pkg::NB_WAYS-1:0] rd_line_i,
   input  logic                                        hit_i,
   input  icache_pkg::way_idx_t                        hit_way_i,
   input  icache_pkg::way_oh_t                         victim_way_i,
   input  logic                                        all_valid_i,
   output logic                                        lfsr_step_o,
   output icache_pkg::tag_wr_t                         tag_wr_o,
   output icache_pkg::data_wr_t                        data_wr_o
);

   icache_pkg::ctrl_state_e state_q, state_d;
   icache_pkg::addr_t       fetch_addr_q;        // Address in lookup or refill
   icache_pkg::way_oh_t     victim_q;
   icache_pkg::set_idx_t    flush_cnt_q;
   logic                    bypass_pend_q;       // Bypass refill still waiting for rvalid
   logic                    save_victim;
   logic                    take_flush_set;

   assign rd_set_o      = fetch_addr_i.set_idx;
   assign lookup_tag_o  = fetch_addr_q.tag;
   assign refill_addr_o = '{tag: fetch_addr_q.tag, set_idx: fetch_addr_q.set_idx, offset: '0};

   ////////////////////////////////////////////////////////////////////////////
   // Next state and outputs
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      state_d             = state_q;
      fetch_gnt_o         = 1'b0;
      fetch_rvalid_o      = 1'b0;
      fetch_rdata_o       = refill_rdata_i;
      refill_req_o        = 1'b0;
      cache_is_bypassed_o = 1'b0;
      cache_is_flushed_o  = 1'b0;
      flush_set_ack_o     = 1'b0;
      rd_en_o             = 1'b0;
      lfsr_step_o         = 1'b0;
      save_victim         = 1'b0;
      take_flush_set      = 1'b0;
      tag_wr_o  = '{ways: '0, set_idx: fetch_addr_q.set_idx, entry: '{1'b1, fetch_addr_q.tag}};
      data_wr_o = '{way: '0, set_idx: fetch_addr_q.set_idx, line: refill_rdata_i};

      case (state_q)
         icache_pkg::DISABLED:
         begin
            cache_is_bypassed_o = 1'b1;
            cache_is_flushed_o  = 1'b1;
            fetch_rvalid_o      = refill_rvalid_i;          // Single beat, straight through
            if (bypass_i)
            begin
               fetch_gnt_o = fetch_req_i && (!bypass_pend_q || refill_rvalid_i);
               if (fetch_gnt_o)
                  state_d = icache_pkg::BYPASS_REFILL;
            end
            else if (!bypass_pend_q)
               state_d = icache_pkg::FLUSH_ALL;            // Enable only once L2 is quiet
         end

         icache_pkg::BYPASS_REFILL:
         begin
            cache_is_bypassed_o = 1'b1;
            cache_is_flushed_o  = 1'b1;
            refill_req_o        = 1'b1;
            if (refill_gnt_i)
               state_d = icache_pkg::DISABLED;
         end

         icache_pkg::FLUSH_ALL:
         begin
            tag_wr_o.ways    = '1;
            tag_wr_o.set_idx = flush_cnt_q;
            tag_wr_o.entry   = '0;
            if (flush_cnt_q == icache_pkg::set_idx_t'(icache_pkg::NB_SETS - 1))
            begin
               cache_is_flushed_o = 1'b1;
               state_d            = icache_pkg::IDLE;
            end
         end

         icache_pkg::FLUSH_SET:
         begin
            // Set index was captured into fetch_addr_q in IDLE
            flush_set_ack_o = 1'b1;
            tag_wr_o.ways   = '1;
            tag_wr_o.entry  = '0;
            state_d         = icache_pkg::IDLE;
         end

         icache_pkg::IDLE:
         begin
            if (bypass_i)
               state_d = icache_pkg::DISABLED;
            else if (flush_i)
               state_d = icache_pkg::FLUSH_ALL;
            else if (flush_set_req_i)
            begin
               take_flush_set = 1'b1;
               state_d        = icache_pkg::FLUSH_SET;
            end
            else if (fetch_req_i)
            begin
               fetch_gnt_o = 1'b1;
               rd_en_o     = 1'b1;
               state_d     = icache_pkg::TAG_LOOKUP;
            end
         end

         icache_pkg::TAG_LOOKUP:
         begin
            if (hit_i)
            begin
               fetch_rvalid_o = 1'b1;
               fetch_rdata_o  = rd_line_i[hit_way_i];
               // Keep hits streaming unless a mode change waits in IDLE
               fetch_gnt_o    = fetch_req_i && !(bypass_i || flush_i || flush_set_req_i);
               rd_en_o        = fetch_gnt_o;
               if (!fetch_gnt_o)
                  state_d = icache_pkg::IDLE;
            end
            else
            begin
               refill_req_o = 1'b1;
               save_victim  = 1'b1;
               lfsr_step_o  = all_valid_i;                  // Random eviction only
               state_d      = refill_gnt_i ? icache_pkg::WAIT_REFILL_DONE
                                           : icache_pkg::WAIT_REFILL_GNT;
            end
         end

         icache_pkg::WAIT_REFILL_GNT:
         begin
            refill_req_o = 1'b1;
            if (refill_gnt_i)
               state_d = icache_pkg::WAIT_REFILL_DONE;
         end

         icache_pkg::WAIT_REFILL_DONE:
         begin
            fetch_rvalid_o = refill_rvalid_i;
            tag_wr_o.ways  = victim_q & {icache_pkg::NB_WAYS{refill_rvalid_i}};
            data_wr_o.way  = victim_q & {icache_pkg::NB_WAYS{refill_rvalid_i}};
            if (refill_rvalid_i)
               state_d = icache_pkg::IDLE;
         end

         default:
            state_d = icache_pkg::DISABLED;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q       <= icache_pkg::DISABLED;
         fetch_addr_q  <= '0;
         victim_q      <= '0;
         flush_cnt_q   <= '0;
         bypass_pend_q <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         if (fetch_gnt_o)
            fetch_addr_q <= fetch_addr_i;
         else if (take_flush_set)
            fetch_addr_q <= flush_set_addr_i;
         if (save_victim)
            victim_q <= victim_way_i;
         if (state_q == icache_pkg::FLUSH_ALL)
            flush_cnt_q <= flush_cnt_q + 1'b1;   // Wraps back to zero on the last set
         if (fetch_gnt_o && (state_q == icache_pkg::DISABLED))
            bypass_pend_q <= 1'b1;
         else if (refill_rvalid_i)
            bypass_pend_q <= 1'b0;
      end
   end

   // L2 request and address held until granted
   refill_hold: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_o && !refill_gnt_i |=> refill_req_o && $stable(refill_addr_o))
      else $error("refill request dropped or changed before grant");

endmodule

// File: hdl/pri_icache.sv
// Private instruction cache top: controller, tag and data arrays, tag check, replacement LFSR
`timescale 1ns/1ps

module pri_icache
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic                bypass_i,
   input  logic                flush_i,
   input  logic                flush_set_req_i,
   input  icache_pkg::addr_t   flush_set_addr_i,
   input  logic                fetch_req_i,
   input  icache_pkg::addr_t   fetch_addr_i,
   output logic                fetch_gnt_o,
   output logic                fetch_rvalid_o,
   output icache_pkg::line_t   fetch_rdata_o,
   output logic                refill_req_o,
   output icache_pkg::addr_t   refill_addr_o,
   input  logic                refill_gnt_i,
   input  logic                refill_rvalid_i,
   input  icache_pkg::line_t   refill_rdata_i,
   output logic                cache_is_bypassed_o,
   output logic                cache_is_flushed_o,
   output logic                flush_set_ack_o
);

   logic                                             rd_en;
   icache_pkg::set_idx_t                             rd_set;
   icache_pkg::tag_t                                 lookup_tag;
   icache_pkg::tag_entry_t [icache_pkg::NB_WAYS-1:0] rd_entry;
   icache_pkg::line_t [icache_pkg::NB_WAYS-1:0]      rd_line;
   logic                                             hit;
   icache_pkg::way_idx_t                             hit_way;
   icache_pkg::way_oh_t                              victim_way;
   icache_pkg::way_oh_t                              random_way;
   logic                                             all_valid;
   logic                                             lfsr_step;
   icache_pkg::tag_wr_t                              tag_wr;
   icache_pkg::data_wr_t                             data_wr;

   icache_ctrl_fsm i_ctrl_fsm
   (
      .clk                 (clk),
      .rst_n               (rst_n),
      .bypass_i            (bypass_i),
      .flush_i             (flush_i),
      .flush_set_req_i     (flush_set_req_i),
      .flush_set_addr_i    (flush_set_addr_i),
      .fetch_req_i         (fetch_req_i),
      .fetch_addr_i        (fetch_addr_i),
      .fetch_gnt_o         (fetch_gnt_o),
      .fetch_rvalid_o      (fetch_rvalid_o),
      .fetch_rdata_o       (fetch_rdata_o),
      .refill_req_o        (refill_req_o),
      .refill_addr_o       (refill_addr_o),
      .refill_gnt_i        (refill_gnt_i),
      .refill_rvalid_i     (refill_rvalid_i),
      .refill_rdata_i      (refill_rdata_i),
      .cache_is_bypassed_o (cache_is_bypassed_o),
      .cache_is_flushed_o  (cache_is_flushed_o),
      .flush_set_ack_o     (flush_set_ack_o),
      .rd_en_o             (rd_en),
      .rd_set_o            (rd_set),
      .lookup_tag_o        (lookup_tag),
      .rd_line_i           (rd_line),
      .hit_i               (hit),
      .hit_way_i           (hit_way),
      .victim_way_i        (victim_way),
      .all_valid_i         (all_valid),
      .lfsr_step_o         (lfsr_step),
      .tag_wr_o            (tag_wr),
      .data_wr_o           (data_wr)
   );

   // Both arrays read on the same enable and set
   icache_tag_array i_tag_array
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .rd_en_i    (rd_en),
      .rd_set_i   (rd_set),
      .rd_entry_o (rd_entry),
      .wr_i       (tag_wr)
   );

   icache_data_array i_data_array
   (
      .clk       (clk),
      .rd_en_i   (rd_en),
      .rd_set_i  (rd_set),
      .rd_line_o (rd_line),
      .wr_i      (data_wr)
   );

   icache_tag_check i_tag_check
   (
      .entry_i      (rd_entry),
      .tag_i        (lookup_tag),
      .random_way_i (random_way),
      .hit_o        (hit),
      .hit_way_o    (hit_way),
      .victim_way_o (victim_way),
      .all_valid_o  (all_valid)
   );

   icache_way_lfsr i_way_lfsr
   (
      .clk    (clk),
      .rst_n  (rst_n),
      .step_i (lfsr_step),
      .way_o  (random_way)
   );

endmodule

// File: verification/tb_refill_mem.sv
// L2 memory model behind the refill port: random grant and response delay, counts refills
`timescale 1ns/1ps

module tb_refill_mem
#(
   parameter int SEED = 1
)
(
   input  logic         clk,
   input  logic         refill_req_i,
   input  logic [31:0]  refill_addr_i,
   output logic         refill_gnt_o,
   output logic         refill_rvalid_o,
   output logic [127:0] refill_rdata_o,
   output logic [31:0]  line_addr_o,      // Line being served
   input  logic [127:0] line_i,           // Its contents
   output int           refill_count_o
);

   logic gnt_ready;                       // Grant allowed in this cycle
   int   seed;
   int   gnt_delay;
   int   resp_delay;

   assign refill_gnt_o   = refill_req_i && gnt_ready;
   assign refill_rdata_o = refill_rvalid_o ? line_i : '0;

   initial
   begin
      seed            = SEED;
      gnt_ready       = 1'b0;
      refill_rvalid_o = 1'b0;
      line_addr_o     = '0;
      refill_count_o  = 0;
      @(posedge clk);
      #1;
      forever
      begin
         gnt_delay  = int'({$random(seed)} % 4);
         resp_delay = 1 + int'({$random(seed)} % 4);
         // Grant delay counts only cycles with a pending request
         if (gnt_delay > 0)
         begin
            while (gnt_delay > 0)
            begin
               @(negedge clk);
               if (refill_req_i)
                  gnt_delay--;
            end
            @(posedge clk);
            #1;
         end
         gnt_ready = 1'b1;
         do
            @(negedge clk);
         while (!refill_gnt_o);
         line_addr_o = refill_addr_i;
         refill_count_o++;
         @(posedge clk);
         #1;
         gnt_ready = 1'b0;
         repeat (resp_delay - 1)
         begin
            @(posedge clk);
            #1;
         end
         refill_rvalid_o = 1'b1;          // Single beat
         @(posedge clk);
         #1;
         refill_rvalid_o = 1'b0;
      end
   end

endmodule

// File: verification/tb_pri_icache.sv
// Testbench for the private instruction cache: bypass, reuse, eviction, flushes, random fetches
`timescale 1ns/1ps

module tb_pri_icache;

   localparam int SEED         = 32'hf870_023e;
   localparam int NB_FETCH     = 8 + 32 + 18 + 16 + 16 + 300;
   localparam int FETCH_CYCLES = 16;      // Lookup, slowest grant and response, request gap
   localparam int FLUSH_CYCLES = 3 * (icache_pkg::NB_SETS + 8);
   localparam int TIMEOUT      = NB_FETCH * FETCH_CYCLES + FLUSH_CYCLES + 20;

   logic                 clk;
   logic                 rst_n;
   logic                 bypass;
   logic                 flush;
   logic                 flush_set_req;
   icache_pkg::addr_t    flush_set_addr;
   logic                 fetch_req;
   icache_pkg::addr_t    fetch_addr;
   logic                 fetch_gnt;
   logic                 fetch_rvalid;
   icache_pkg::line_t    fetch_rdata;
   logic                 refill_req;
   icache_pkg::addr_t    refill_addr;
   logic                 refill_gnt;
   logic                 refill_rvalid;
   icache_pkg::line_t    refill_rdata;
   logic                 cache_is_bypassed;
   logic                 cache_is_flushed;
   logic                 flush_set_ack;
   logic [31:0]          mem_addr;
   icache_pkg::line_t    mem_data;
   int                   refill_cnt;

   icache_pkg::line_t    exp_q[$];        // Expected lines in grant order
   icache_pkg::addr_t    exp_addr_q[$];
   icache_pkg::line_t    exp_line;
   icache_pkg::addr_t    exp_addr;
   string                test_name;
   int                   seed;
   int                   err_cnt;
   int                   check_cnt;
   int                   ack_cnt;
   int                   ack_start;
   int                   refill_start;
   int                   cycle_cnt;
   int                   idx;

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   // L2 contents: line address and its inverse, twice
   function automatic icache_pkg::line_t mem_line(input logic [31:0] line_addr);
      return {line_addr, ~line_addr, line_addr, ~line_addr};
   endfunction

   function automatic logic [31:0] line_base(input icache_pkg::addr_t addr);
      return {addr.tag, addr.set_idx, 4'h0};
   endfunction

   function automatic icache_pkg::addr_t make_addr(input int tag_no, input int set_no,
                                                   input int off);
      icache_pkg::addr_t a;
      a.tag     = icache_pkg::tag_t'(24'h00_1000 + tag_no);
      a.set_idx = icache_pkg::set_idx_t'(set_no);
      a.offset  = 4'(off);
      return a;
   endfunction

   function automatic int rand_below(input int n);
      return int'({$random(seed)} % n);
   endfunction

   assign mem_data = mem_line(mem_addr);

   ////////////////////////////////////////////////////////////////////////////
   // Clock, DUT and L2 model
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   pri_icache i_pri_icache
   (
      .clk                 (clk),
      .rst_n               (rst_n),
      .bypass_i            (bypass),
      .flush_i             (flush),
      .flush_set_req_i     (flush_set_req),
      .flush_set_addr_i    (flush_set_addr),
      .fetch_req_i         (fetch_req),
      .fetch_addr_i        (fetch_addr),
      .fetch_gnt_o         (fetch_gnt),
      .fetch_rvalid_o      (fetch_rvalid),
      .fetch_rdata_o       (fetch_rdata),
      .refill_req_o        (refill_req),
      .refill_addr_o       (refill_addr),
      .refill_gnt_i        (refill_gnt),
      .refill_rvalid_i     (refill_rvalid),
      .refill_rdata_i      (refill_rdata),
      .cache_is_bypassed_o (cache_is_bypassed),
      .cache_is_flushed_o  (cache_is_flushed),
      .flush_set_ack_o     (flush_set_ack)
   );

   tb_refill_mem #(.SEED(SEED)) i_refill_mem
   (
      .clk             (clk),
      .refill_req_i    (refill_req),
      .refill_addr_i   (refill_addr),
      .refill_gnt_o    (refill_gnt),
      .refill_rvalid_o (refill_rvalid),
      .refill_rdata_o  (refill_rdata),
      .line_addr_o     (mem_addr),
      .line_i          (mem_data),
      .refill_count_o  (refill_cnt)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Checker and monitors, sampled mid-cycle
   ////////////////////////////////////////////////////////////////////////////

   always @(negedge clk)
   begin
      if (rst_n && fetch_rvalid)
      begin
         if (exp_q.size() == 0)
         begin
            err_cnt++;
            $display("Response arrived with no fetch outstanding in test %s", test_name);
         end
         else
         begin
            exp_line = exp_q.pop_front();
            exp_addr = exp_addr_q.pop_front();
            check_cnt++;
            if (fetch_rdata !== exp_line)
            begin
               err_cnt++;
               $display("FAIL %s: addr %h expected %h actual %h",
                        test_name, exp_addr, exp_line, fetch_rdata);
            end
         end
      end
      if (flush_set_ack)
         ack_cnt++;
   end

   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout after %0d cycles in test %s with %0d fetches outstanding",
               cycle_cnt, test_name, exp_q.size());
      $display("Simulation FAILED");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Driver tasks, all called and returning just after a rising edge
   ////////////////////////////////////////////////////////////////////////////

   task automatic issue_fetch(input icache_pkg::addr_t addr);
      fetch_req  = 1'b1;
      fetch_addr = addr;
      exp_q.push_back(mem_line(line_base(addr)));
      exp_addr_q.push_back(addr);
      do
         @(negedge clk);
      while (!fetch_gnt);
      @(posedge clk);                     // Grant edge
      #1;
   endtask

   task automatic idle_gap(input int n);
      fetch_req = 1'b0;
      repeat (n)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic drain_fetches();
      fetch_req = 1'b0;
      while (exp_q.size() != 0)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic wait_flushed();
      do
         @(negedge clk);
      while (!cache_is_flushed);          // High only in the last flush cycle
      @(posedge clk);
      #1;
   endtask

   task automatic flush_one_set(input int set_no);
      flush_set_addr = make_addr(0, set_no, 0);
      flush_set_req  = 1'b1;
      do
         @(negedge clk);
      while (!flush_set_ack);
      @(posedge clk);
      #1;
      flush_set_req = 1'b0;
      idle_gap(2);                        // Room for a second ack to show up
   endtask

   task automatic check_refills(input int exp_cnt);
      check_cnt++;
      if (refill_cnt - refill_start != exp_cnt)
      begin
         err_cnt++;
         $display("FAIL %s: refills expected %0d actual %0d",
                  test_name, exp_cnt, refill_cnt - refill_start);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Scenarios
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      seed           = SEED;
      rst_n          = 1'b0;
      bypass         = 1'b1;
      flush          = 1'b0;
      flush_set_req  = 1'b0;
      flush_set_addr = '0;
      fetch_req      = 1'b0;
      fetch_addr     = '0;
      err_cnt        = 0;
      check_cnt      = 0;
      ack_cnt        = 0;
      test_name      = "reset";
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;

      test_name = "bypass";
      @(negedge clk);
      if (!cache_is_bypassed)
      begin
         err_cnt++;
         $display("cache_is_bypassed_o stays low while bypass_i is high");
      end
      @(posedge clk);
      #1;
      refill_start = refill_cnt;
      for (int i = 0; i < 8; i++)
         issue_fetch(make_addr(0, i % 2, i));   // Repeats still go to L2
      drain_fetches();
      check_refills(8);

      test_name = "enable";
      bypass    = 1'b0;
      do
         @(negedge clk);
      while (cache_is_bypassed);
      wait_flushed();
      refill_start = refill_cnt;
      for (int s = 0; s < 4; s++)
         for (int t = 0; t < 4; t++)
            issue_fetch(make_addr(t, s, rand_below(16)));
      drain_fetches();
      check_refills(16);

      test_name    = "reuse";
      refill_start = refill_cnt;
      for (int t = 3; t >= 0; t--)
         for (int s = 0; s < 4; s++)
            issue_fetch(make_addr(t, s, rand_below(16)));
      drain_fetches();
      check_refills(0);

      // Six tags in a four-way set
      test_name = "evict";
      for (int r = 0; r < 3; r++)
         for (int t = 0; t < 6; t++)
            issue_fetch(make_addr(t, 8, r));
      drain_fetches();

      test_name = "set_flush";
      ack_start = ack_cnt;
      flush_one_set(1);
      check_cnt++;
      if (ack_cnt - ack_start != 1)
      begin
         err_cnt++;
         $display("FAIL %s: ack pulses expected 1 actual %0d", test_name, ack_cnt - ack_start);
      end
      refill_start = refill_cnt;
      for (int t = 0; t < 4; t++)
         issue_fetch(make_addr(t, 1, 0));
      drain_fetches();
      check_refills(4);
      refill_start = refill_cnt;
      for (int s = 0; s < 4; s++)
         for (int t = 0; t < 4; t++)
            if (s != 1)
               issue_fetch(make_addr(t, s, 0));
      drain_fetches();
      check_refills(0);

      test_name = "full_flush";
      flush     = 1'b1;
      wait_flushed();
      flush        = 1'b0;
      refill_start = refill_cnt;
      for (int s = 0; s < 4; s++)
         for (int t = 0; t < 4; t++)
            issue_fetch(make_addr(t, s, 0));
      drain_fetches();
      check_refills(16);

      // 64 lines over sets 8 to 15, eight tags each
      test_name = "random";
      for (int i = 0; i < 300; i++)
      begin
         idx = rand_below(64);
         issue_fetch(make_addr(16 + idx / 8, 8 + idx % 8, rand_below(16)));
         idle_gap(rand_below(3));
      end
      drain_fetches();

      $display("Run complete: %0d checks, %0d errors, %0d refills",
               check_cnt, err_cnt, refill_cnt);
      if (err_cnt == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: vlog.f
hdl/icache_pkg.sv
hdl/icache_tag_array.sv
hdl/icache_data_array.sv
hdl/icache_tag_check.sv
hdl/icache_way_lfsr.sv
hdl/icache_ctrl_fsm.sv
hdl/pri_icache.sv
verification/tb_refill_mem.sv
verification/tb_pri_icache.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_pri_icache -f vlog.f

./obj_dir/Vtb_pri_icache > sim.log 2>&1
cat sim.log

if grep -qx "Simulation PASSED" sim.log
then
   echo "run_sim: pass"
   exit 0
else
   echo "run_sim: fail"
   exit 1
fi
